//--- sim/exec_vectors.txt
// one 64-bit word per micro-op: op _ rd _ rs1 _ rs2 _ imm _ expected commit data
// op codes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 li, 8 mul
7_1_0_0_1234_00001234
7_2_0_0_fff0_fffffff0
7_3_0_0_0004_00000004
0_4_1_2_0000_00001224
1_5_1_3_0000_00001230
2_6_1_2_0000_00001230
3_7_2_3_0000_fffffff4
4_6_1_4_0000_00000010
5_5_1_3_0000_00012340
6_4_2_3_0000_0fffffff
8_1_1_5_0000_14b5a900
8_2_2_3_0000_ffffffc0
8_6_7_7_0000_00000090
4_5_4_3_0000_0ffffffb
0_3_6_1_0000_14b5a990
7_0_0_0_7fff_00007fff
0_7_0_3_0000_14b5a990
8_4_2_5_0000_00000140
1_1_0_4_0000_fffffec0
6_2_1_3_0000_0000ffff
5_6_2_3_0000_ffff0000
8_5_2_2_0000_fffe0001
2_7_5_6_0000_fffe0000

//--- exec_cluster.f
verilog/exec_pkg.sv
verilog/dispatch_unit.sv
verilog/reg_file_sb.sv
verilog/alu_pipe.sv
verilog/mul_pipe.sv
verilog/commit_buffer.sv
verilog/exec_cluster.sv
sim/commit_checker.sv
sim/tb_exec_cluster.sv

//--- sim/tb_exec_cluster.sv
// testbench top for the execute cluster
// clock, reset, vector-driven req/ack issue with random idle gaps,
// cycle watchdog and the closing summary
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;
  import exec_pkg::*;

  localparam int max_vectors = 64;
  localparam int half_period = 4;

  logic        clock;
  logic        reset;
  logic        req;
  uop_t        uop;
  logic        ack;
  logic        commit_valid;
  result_t     commit;
  logic [15:0] retired_count;

  logic [63:0] vec_mem [max_vectors];
  int          num_vectors;
  int          cycle_limit;
  int          cycle_count;
  logic [15:0] lfsr_q;
  int          local_pass;
  int          local_fail;
  int          commit_count;
  int          check_pass;
  int          check_fail;

  exec_cluster i_exec_cluster (
    .clock         (clock),
    .reset         (reset),
    .req           (req),
    .uop           (uop),
    .ack           (ack),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .retired_count (retired_count)
  );

  commit_checker i_commit_checker (
    .clock        (clock),
    .reset        (reset),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_count (commit_count),
    .pass_count   (check_pass),
    .fail_count   (check_fail)
  );

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the lsb
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  // 0 to 3 idle cycles, one lfsr step per bit
  task automatic draw_gap(output int gap);
    lfsr_q = lfsr_next(lfsr_q);
    gap    = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    gap    = gap + 2 * lfsr_q[0];
  endtask

  task automatic load_vectors();
    $readmemh("sim/exec_vectors.txt", vec_mem);
    num_vectors = 0;
    while ((num_vectors < max_vectors) && !$isunknown(vec_mem[num_vectors])) begin
      num_vectors++;
    end
    cycle_limit = num_vectors * 12 + 100;
  endtask

  // nothing may move before the first req
  task automatic check_idle();
    int errors;
    errors = 0;
    repeat (4) begin
      @(negedge clock);
      if (ack !== 1'b0) begin
        $display("mismatch ack after reset: got %h expected 0", ack);
        errors++;
      end
      if (commit_valid !== 1'b0) begin
        $display("mismatch commit_valid after reset: got %h expected 0", commit_valid);
        errors++;
      end
      if (retired_count !== 16'h0000) begin
        $display("mismatch retired_count after reset: got %h expected 0000", retired_count);
        errors++;
      end
    end
    if (errors == 0) begin
      $display("reset idle: pass");
      local_pass++;
    end else begin
      $display("reset idle: fail");
      local_fail++;
    end
  endtask

  // one four-phase handshake, called on a falling edge
  task automatic run_handshake(input logic [63:0] word);
    uop.op  = op_t'(word[63:60]);
    uop.rd  = word[58:56];
    uop.rs1 = word[54:52];
    uop.rs2 = word[50:48];
    uop.imm = word[47:32];
    req     = 1'b1;
    @(negedge clock);
    while (!ack) @(negedge clock);
    req = 1'b0;
    @(negedge clock);
    while (ack) @(negedge clock);
  endtask

  task automatic check_retired();
    if (retired_count !== 16'(num_vectors)) begin
      $display("mismatch retired_count: got %h expected %h", retired_count, 16'(num_vectors));
      $display("retired count: fail");
      local_fail++;
    end else begin
      $display("retired count: pass");
      local_pass++;
    end
  endtask

  // watchdog over the whole run
  always @(posedge clock) begin
    if (reset) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("timeout after %0d cycles, commit for vector %0d of %0d never arrived",
                 cycle_count, commit_count, num_vectors);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    int gap;
    int i;
    reset      = 1'b1;
    req        = 1'b0;
    uop        = '0;
    lfsr_q     = 16'd46802;
    local_pass = 0;
    local_fail = 0;
    load_vectors();
    repeat (5) @(negedge clock);
    reset = 1'b0;
    if (num_vectors == 0) begin
      $display("no vectors could be read from sim/exec_vectors.txt");
      local_fail++;
    end else begin
      check_idle();
      for (i = 0; i < num_vectors; i++) begin
        run_handshake(vec_mem[i]);
        // next op follows a multiply with no idle gap
        if (vec_mem[i][63:60] == op_mul) begin
          gap = 0;
        end else begin
          draw_gap(gap);
        end
        repeat (gap) @(negedge clock);
      end
      while (commit_count < num_vectors) @(negedge clock);
      // room for any stray extra commit
      repeat (4) @(negedge clock);
      check_retired();
    end
    $display("summary: %0d tests, %0d passed, %0d failed",
             local_pass + local_fail + check_pass + check_fail,
             local_pass + check_pass, local_fail + check_fail);
    if ((local_fail + check_fail) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/commit_checker.sv
// commit port monitor for the execute cluster
// checks tag order, destination and data of each commit against the vectors
`timescale 1ns/1ps
`default_nettype none

module commit_checker (
  input  logic              clock,
  input  logic              reset,
  input  logic              commit_valid,
  input  exec_pkg::result_t commit,
  output int                commit_count,
  output int                pass_count,
  output int                fail_count
);
  import exec_pkg::*;

  localparam int max_vectors = 64;

  logic [63:0] vec_mem [max_vectors];
  int          num_vectors;

  initial begin
    $readmemh("sim/exec_vectors.txt", vec_mem);
    num_vectors = 0;
    while ((num_vectors < max_vectors) && !$isunknown(vec_mem[num_vectors])) begin
      num_vectors++;
    end
  end

  // commit outputs are registered, so mid-cycle is stable
  always @(negedge clock) begin : compare
    tag_t       exp_tag;
    reg_index_t exp_rd;
    data_t      exp_data;
    logic       ok;
    if (reset) begin
      commit_count <= 0;
      pass_count   <= 0;
      fail_count   <= 0;
    end else if (commit_valid) begin
      if (commit_count >= num_vectors) begin
        $display("commit with tag %h arrived after the last vector had retired", commit.tag);
        fail_count <= fail_count + 1;
      end else begin
        // program order, wrapping at num_tags
        exp_tag  = tag_t'(commit_count % num_tags);
        exp_rd   = vec_mem[commit_count][58:56];
        exp_data = vec_mem[commit_count][31:0];
        ok       = 1'b1;
        if (commit.tag !== exp_tag) begin
          $display("mismatch commit.tag on vector %0d: got %h expected %h",
                   commit_count, commit.tag, exp_tag);
          ok = 1'b0;
        end
        if (commit.rd !== exp_rd) begin
          $display("mismatch commit.rd on vector %0d: got %h expected %h",
                   commit_count, commit.rd, exp_rd);
          ok = 1'b0;
        end
        if (commit.data !== exp_data) begin
          $display("mismatch commit.data on vector %0d: got %h expected %h",
                   commit_count, commit.data, exp_data);
          ok = 1'b0;
        end
        if (ok) begin
          $display("vector %0d op %h rd %0d: pass",
                   commit_count, vec_mem[commit_count][63:60], exp_rd);
          pass_count <= pass_count + 1;
        end else begin
          $display("vector %0d: fail", commit_count);
          fail_count <= fail_count + 1;
        end
      end
      commit_count <= commit_count + 1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/exec_cluster.sv
// execute cluster top: dispatch, register file,
// ALU and multiply pipes, commit buffer
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  logic              clock,
  input  logic              reset,
  input  logic              req,
  input  exec_pkg::uop_t    uop,
  output logic              ack,
  output logic              commit_valid,
  output exec_pkg::result_t commit,
  output logic [15:0]       retired_count
);
  import exec_pkg::*;

  reg_index_t rd_a_index;
  reg_index_t rd_b_index;
  reg_index_t rd_d_index;
  data_t      rd_a_data;
  data_t      rd_b_data;
  logic       busy_a;
  logic       busy_b;
  logic       busy_d;
  logic       set_busy;
  reg_index_t set_busy_index;
  issue_t     alu_issue;
  issue_t     mul_issue;
  logic       alu_done;
  result_t    alu_result;
  logic       mul_done;
  result_t    mul_result;
  logic       wr_en;
  reg_index_t wr_index;
  data_t      wr_data;

  dispatch_unit i_dispatch (
    .clock          (clock),
    .reset          (reset),
    .req            (req),
    .uop            (uop),
    .ack            (ack),
    .rd_a_index     (rd_a_index),
    .rd_b_index     (rd_b_index),
    .rd_d_index     (rd_d_index),
    .rd_a_data      (rd_a_data),
    .rd_b_data      (rd_b_data),
    .busy_a         (busy_a),
    .busy_b         (busy_b),
    .busy_d         (busy_d),
    .set_busy       (set_busy),
    .set_busy_index (set_busy_index),
    .commit_valid   (commit_valid),
    .alu_issue      (alu_issue),
    .mul_issue      (mul_issue)
  );

  reg_file_sb i_reg_file (
    .clock          (clock),
    .reset          (reset),
    .rd_a_index     (rd_a_index),
    .rd_b_index     (rd_b_index),
    .rd_d_index     (rd_d_index),
    .rd_a_data      (rd_a_data),
    .rd_b_data      (rd_b_data),
    .busy_a         (busy_a),
    .busy_b         (busy_b),
    .busy_d         (busy_d),
    .set_busy       (set_busy),
    .set_busy_index (set_busy_index),
    .wr_en          (wr_en),
    .wr_index       (wr_index),
    .wr_data        (wr_data)
  );

  alu_pipe i_alu (
    .clock  (clock),
    .reset  (reset),
    .issue  (alu_issue),
    .done   (alu_done),
    .result (alu_result)
  );

  mul_pipe i_mul (
    .clock  (clock),
    .reset  (reset),
    .issue  (mul_issue),
    .done   (mul_done),
    .result (mul_result)
  );

  commit_buffer i_commit (
    .clock         (clock),
    .reset         (reset),
    .alu_done      (alu_done),
    .alu_result    (alu_result),
    .mul_done      (mul_done),
    .mul_result    (mul_result),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .retired_count (retired_count)
  );

endmodule

`default_nettype wire

//--- verilog/commit_buffer.sv
// tag-indexed completion slots with in-order commit
// drives register writeback, the commit port and the retire count
`timescale 1ns/1ps
`default_nettype none

module commit_buffer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 alu_done,
  input  exec_pkg::result_t    alu_result,
  input  logic                 mul_done,
  input  exec_pkg::result_t    mul_result,
  output logic                 wr_en,
  output exec_pkg::reg_index_t wr_index,
  output exec_pkg::data_t      wr_data,
  output logic                 commit_valid,
  output exec_pkg::result_t    commit,
  output logic [15:0]          retired_count
);
  import exec_pkg::*;

  result_t             slot_q [num_tags];
  logic [num_tags-1:0] filled_q;
  tag_t                head_q;
  result_t             head_entry;
  logic                head_ready;

  // head slot, or a result arriving for it this cycle
  always_comb begin
    head_entry = slot_q[head_q];
    head_ready = filled_q[head_q];
    if (alu_done && (alu_result.tag == head_q)) begin
      head_entry = alu_result;
      head_ready = 1'b1;
    end
    if (mul_done && (mul_result.tag == head_q)) begin
      head_entry = mul_result;
      head_ready = 1'b1;
    end
  end

  // r0 commits but never writes
  assign wr_en    = head_ready && (head_entry.rd != '0);
  assign wr_index = head_entry.rd;
  assign wr_data  = head_entry.data;

  // two write ports, tags never collide
  always_ff @(posedge clock) begin
    if (alu_done) slot_q[alu_result.tag] <= alu_result;
    if (mul_done) slot_q[mul_result.tag] <= mul_result;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      filled_q      <= '0;
      head_q        <= '0;
      commit_valid  <= 1'b0;
      retired_count <= '0;
    end else begin
      if (alu_done) filled_q[alu_result.tag] <= 1'b1;
      if (mul_done) filled_q[mul_result.tag] <= 1'b1;
      // freeing the head overrides a same-cycle fill of it
      if (head_ready) begin
        filled_q[head_q] <= 1'b0;
        head_q           <= head_q + 1'b1;
        retired_count    <= retired_count + 1'b1;
      end
      commit_valid <= head_ready;
    end
  end

  always_ff @(posedge clock) begin
    if (head_ready) commit <= head_entry;
  end

endmodule

`default_nettype wire

//--- verilog/mul_pipe.sv
// three-stage 32x32 multiplier, low half of the product only
// partial products, sum, then output register
`timescale 1ns/1ps
`default_nettype none

module mul_pipe (
  input  logic              clock,
  input  logic              reset,
  input  exec_pkg::issue_t  issue,
  output logic              done,
  output exec_pkg::result_t result
);
  import exec_pkg::*;

  typedef struct packed {
    logic       valid;
    tag_t       tag;
    reg_index_t rd;
  } mul_meta_t;

  mul_meta_t meta_q [mul_stages];
  data_t     ll_q;
  data_t     lh_q;
  data_t     hl_q;
  data_t     sum_q;
  data_t     prod_q;

  // tag and rd ride along with each stage
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < mul_stages; i++) begin
        meta_q[i].valid <= 1'b0;
      end
    end else begin
      meta_q[0] <= '{valid: issue.valid, tag: issue.tag, rd: issue.rd};
      for (int i = 1; i < mul_stages; i++) begin
        meta_q[i] <= meta_q[i-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    // stage 1, hi x hi only lands above bit 31
    ll_q   <= issue.src_a[15:0] * issue.src_b[15:0];
    lh_q   <= issue.src_a[15:0] * issue.src_b[31:16];
    hl_q   <= issue.src_a[31:16] * issue.src_b[15:0];
    // stage 2
    sum_q  <= ll_q + ((lh_q + hl_q) << 16);
    // stage 3
    prod_q <= sum_q;
  end

  assign done = meta_q[mul_stages-1].valid;

  always_comb begin
    result.tag  = meta_q[mul_stages-1].tag;
    result.rd   = meta_q[mul_stages-1].rd;
    result.data = prod_q;
  end

endmodule

`default_nettype wire

//--- verilog/alu_pipe.sv
// single-cycle integer ALU
// add, sub, logic ops, shifts and load-immediate
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
  input  logic              clock,
  input  logic              reset,
  input  exec_pkg::issue_t  issue,
  output logic              done,
  output exec_pkg::result_t result
);
  import exec_pkg::*;

  data_t imm_ext;
  data_t alu_out;

  assign imm_ext = {{($bits(data_t) - $bits(imm_t)){issue.imm[$bits(imm_t)-1]}}, issue.imm};

  always_comb begin
    case (issue.op)
      op_add:  alu_out = issue.src_a + issue.src_b;
      op_sub:  alu_out = issue.src_a - issue.src_b;
      op_and:  alu_out = issue.src_a & issue.src_b;
      op_or:   alu_out = issue.src_a | issue.src_b;
      op_xor:  alu_out = issue.src_a ^ issue.src_b;
      // shift amount from low 5 bits
      op_sll:  alu_out = issue.src_a << issue.src_b[4:0];
      op_srl:  alu_out = issue.src_a >> issue.src_b[4:0];
      op_li:   alu_out = imm_ext;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= issue.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (issue.valid) begin
      result.tag  <= issue.tag;
      result.rd   <= issue.rd;
      result.data <= alu_out;
    end
  end

endmodule

`default_nettype wire

//--- verilog/reg_file_sb.sv
// architectural register file with per-register busy bits
// r0 reads zero and never goes busy
`timescale 1ns/1ps
`default_nettype none

module reg_file_sb (
  input  logic                 clock,
  input  logic                 reset,
  input  exec_pkg::reg_index_t rd_a_index,
  input  exec_pkg::reg_index_t rd_b_index,
  input  exec_pkg::reg_index_t rd_d_index,
  output exec_pkg::data_t      rd_a_data,
  output exec_pkg::data_t      rd_b_data,
  output logic                 busy_a,
  output logic                 busy_b,
  output logic                 busy_d,
  input  logic                 set_busy,
  input  exec_pkg::reg_index_t set_busy_index,
  input  logic                 wr_en,
  input  exec_pkg::reg_index_t wr_index,
  input  exec_pkg::data_t      wr_data
);
  import exec_pkg::*;

  data_t               regs_q [num_regs];
  logic [num_regs-1:0] busy_q;

  assign rd_a_data = (rd_a_index == '0) ? '0 : regs_q[rd_a_index];
  assign rd_b_data = (rd_b_index == '0) ? '0 : regs_q[rd_b_index];

  // busy_q[0] is never set
  assign busy_a = busy_q[rd_a_index];
  assign busy_b = busy_q[rd_b_index];
  assign busy_d = busy_q[rd_d_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      // commit write frees the register at the same edge
      if (wr_en && (wr_index != '0)) begin
        regs_q[wr_index] <= wr_data;
        busy_q[wr_index] <= 1'b0;
      end
      if (set_busy && (set_busy_index != '0)) begin
        busy_q[set_busy_index] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dispatch_unit.sv
// issue side of the cluster: four-phase req/ack handshake,
// scoreboard hazard check, operand read, tag stamping and pipe routing
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req,
  input  exec_pkg::uop_t       uop,
  output logic                 ack,
  output exec_pkg::reg_index_t rd_a_index,
  output exec_pkg::reg_index_t rd_b_index,
  output exec_pkg::reg_index_t rd_d_index,
  input  exec_pkg::data_t      rd_a_data,
  input  exec_pkg::data_t      rd_b_data,
  input  logic                 busy_a,
  input  logic                 busy_b,
  input  logic                 busy_d,
  output logic                 set_busy,
  output exec_pkg::reg_index_t set_busy_index,
  input  logic                 commit_valid,
  output exec_pkg::issue_t     alu_issue,
  output exec_pkg::issue_t     mul_issue
);
  import exec_pkg::*;

  typedef enum logic [1:0] {
    idle,
    acked,
    wait_drop
  } hs_state_t;

  hs_state_t                 state_q;
  logic [$clog2(num_tags):0] outstanding_q;
  tag_t                      tag_q;
  logic                      uses_src;
  logic                      is_mul;
  logic                      hazard;
  logic                      fire;
  issue_t                    issue_word;

  // operands come straight off the held uop
  assign rd_a_index = uop.rs1;
  assign rd_b_index = uop.rs2;
  assign rd_d_index = uop.rd;

  // load-immediate reads no register
  assign uses_src = (uop.op != op_li);
  assign is_mul   = (uop.op == op_mul);

  // rd busy check also covers WAW
  assign hazard = (uses_src && (busy_a || busy_b)) || busy_d;
  assign fire   = req && (state_q == idle) && !hazard && (outstanding_q < num_tags);

  assign set_busy       = fire && (uop.rd != '0);
  assign set_busy_index = uop.rd;

  assign ack = (state_q != idle);

  always_comb begin
    issue_word.valid = 1'b1;
    issue_word.op    = uop.op;
    issue_word.rd    = uop.rd;
    issue_word.tag   = tag_q;
    issue_word.imm   = is_mul ? '0 : uop.imm;
    issue_word.src_a = uses_src ? rd_a_data : '0;
    issue_word.src_b = uses_src ? rd_b_data : '0;
  end

  // handshake FSM, ack held until req drops
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= idle;
    end else begin
      case (state_q)
        idle:      if (fire) state_q <= acked;
        acked:     state_q <= req ? wait_drop : idle;
        wait_drop: if (!req) state_q <= idle;
        default:   state_q <= idle;
      endcase
    end
  end

  // tag stamping and in-flight count
  always_ff @(posedge clock) begin
    if (reset) begin
      tag_q         <= '0;
      outstanding_q <= '0;
    end else begin
      if (fire) tag_q <= tag_q + 1'b1;
      case ({fire, commit_valid})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // one-cycle issue strobes toward the pipes
  always_ff @(posedge clock) begin
    if (reset) begin
      alu_issue.valid <= 1'b0;
      mul_issue.valid <= 1'b0;
    end else begin
      alu_issue.valid <= 1'b0;
      mul_issue.valid <= 1'b0;
      if (fire && is_mul) mul_issue <= issue_word;
      if (fire && !is_mul) alu_issue <= issue_word;
    end
  end

endmodule

`default_nettype wire

//--- verilog/exec_pkg.sv
// sizes, opcodes and field types for the integer execute cluster
// micro-op, issue and result structs shared by every block
`default_nettype none

package exec_pkg;

  localparam int num_regs   = 8;
  localparam int num_tags   = 16;
  localparam int mul_stages = 3;

  typedef logic [$clog2(num_regs)-1:0] reg_index_t;
  typedef logic [31:0]                 data_t;
  typedef logic [15:0]                 imm_t;
  typedef logic [$clog2(num_tags)-1:0] tag_t;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_li  = 4'd7,
    op_mul = 4'd8
  } op_t;

  // micro-op as it arrives on the issue handshake
  typedef struct packed {
    op_t        op;
    reg_index_t rd;
    reg_index_t rs1;
    reg_index_t rs2;
    imm_t       imm;
  } uop_t;

  // micro-op with operands read and tag stamped
  typedef struct packed {
    logic       valid;
    op_t        op;
    reg_index_t rd;
    tag_t       tag;
    imm_t       imm;
    data_t      src_a;
    data_t      src_b;
  } issue_t;

  // completion from a pipe or a commit to the outside
  typedef struct packed {
    tag_t       tag;
    reg_index_t rd;
    data_t      data;
  } result_t;

endpackage

`default_nettype wire
